// File: hdl/rv32e_reg_pkg.sv
// Shared widths, CSR encodings and reset values for the RV32E register state.
// Only the four machine CSRs used by the core are given slots here.
// Addresses outside the listed ones are treated by csr_file as ecall.

package rv32e_reg_pkg;

    // plain vector types
    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [3:0]  gpr_idx_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [2:0]  funct3_t;

    // slots of the CSR array
    typedef enum logic [1:0] {
        CSR_MSTATUS = 2'd0,
        CSR_MTVEC   = 2'd1,
        CSR_MEPC    = 2'd2,
        CSR_MCAUSE  = 2'd3
    } csr_idx_e;

    // number of general-purpose registers in RV32E
    localparam int GPR_NUM = 16;

    // CSR address field values, bits 31:20 of the instruction
    // ecall and mret share the SYSTEM opcode, so they appear here too
    localparam csr_addr_t ADDR_ECALL   = 12'h000;
    localparam csr_addr_t ADDR_MSTATUS = 12'h300;
    localparam csr_addr_t ADDR_MRET    = 12'h302;
    localparam csr_addr_t ADDR_MTVEC   = 12'h305;
    localparam csr_addr_t ADDR_MEPC    = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE  = 12'h342;

    // funct3 of SYSTEM instructions
    localparam funct3_t F3_PRIV  = 3'b000;
    localparam funct3_t F3_CSRRW = 3'b001;
    localparam funct3_t F3_CSRRS = 3'b010;

    // MPP = machine mode after reset
    localparam word_t MSTATUS_RST = 32'h0000_1800;
    // environment call from M-mode
    localparam word_t MCAUSE_RST  = 32'h0000_000b;

endpackage

// File: hdl/gpr_file.sv
// RV32E general-purpose register file, sixteen 32-bit words.
// Two combinational read ports and one write port on the rising edge.
// x0 is cleared on reset and never written, so it always reads zero.
// A read in the cycle of a write returns the old value (no bypass).

module gpr_file (
    input  logic                    clk,
    input  logic                    rst,
    input  rv32e_reg_pkg::gpr_idx_t rs1,
    input  rv32e_reg_pkg::gpr_idx_t rs2,
    input  rv32e_reg_pkg::gpr_idx_t rd,
    input  logic                    reg_wr,
    input  rv32e_reg_pkg::word_t    wb_data,
    output rv32e_reg_pkg::word_t    rs1_data,
    output rv32e_reg_pkg::word_t    rs2_data
);

    import rv32e_reg_pkg::*;

    word_t regs [GPR_NUM];

    logic wr_en;

    // writes to x0 are dropped
    assign wr_en = reg_wr && (rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < GPR_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd] <= wb_data;
        end
    end

    // read ports, current state only
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

// File: hdl/csr_file.sv
// Machine CSR store: mstatus, mtvec, mepc and mcause.
// The address field picks separate read and write slots, so ecall can read
// mtvec while storing into mepc. Unknown addresses behave like ecall.
// Reads are combinational; a write lands on the rising edge with csr_wr.

module csr_file (
    input  logic                     clk,
    input  logic                     rst,
    input  rv32e_reg_pkg::csr_addr_t csr_addr,
    input  logic                     csr_wr,
    input  rv32e_reg_pkg::word_t     csr_wdata,
    output rv32e_reg_pkg::word_t     csr_rdata
);

    import rv32e_reg_pkg::*;

    word_t csr_q [4];

    csr_idx_e rd_idx;
    csr_idx_e wr_idx;

    // address field to read and write slots
    always_comb begin
        case (csr_addr)
            ADDR_ECALL: begin
                // trap entry: fetch handler, save pc
                rd_idx = CSR_MTVEC;
                wr_idx = CSR_MEPC;
            end
            ADDR_MTVEC: begin
                rd_idx = CSR_MTVEC;
                wr_idx = CSR_MTVEC;
            end
            ADDR_MSTATUS: begin
                rd_idx = CSR_MSTATUS;
                wr_idx = CSR_MSTATUS;
            end
            ADDR_MCAUSE: begin
                rd_idx = CSR_MCAUSE;
                wr_idx = CSR_MCAUSE;
            end
            ADDR_MEPC: begin
                rd_idx = CSR_MEPC;
                wr_idx = CSR_MEPC;
            end
            ADDR_MRET: begin
                // return address comes from mepc
                rd_idx = CSR_MEPC;
                wr_idx = CSR_MEPC;
            end
            default: begin
                rd_idx = CSR_MTVEC;
                wr_idx = CSR_MEPC;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            csr_q[CSR_MSTATUS] <= MSTATUS_RST;
            csr_q[CSR_MTVEC]   <= '0;
            csr_q[CSR_MEPC]    <= '0;
            csr_q[CSR_MCAUSE]  <= MCAUSE_RST;
        end else if (csr_wr) begin
            csr_q[wr_idx] <= csr_wdata;
        end
    end

    // read slot, pre-edge value
    assign csr_rdata = csr_q[rd_idx];

endmodule

// File: hdl/csr_update.sv
// New CSR value for a SYSTEM instruction, chosen by funct3.
// ecall stores pc, csrrw stores rs1, csrrs stores rs1 OR the old CSR value.
// CSR immediate forms are not supported and fall back to pc.

module csr_update (
    input  rv32e_reg_pkg::funct3_t funct3,
    input  rv32e_reg_pkg::word_t   pc,
    input  rv32e_reg_pkg::word_t   rs1_data,
    input  rv32e_reg_pkg::word_t   csr_rdata,
    output rv32e_reg_pkg::word_t   csr_wdata
);

    import rv32e_reg_pkg::*;

    always_comb begin
        case (funct3)
            // ecall and mret
            F3_PRIV: begin
                csr_wdata = pc;
            end
            F3_CSRRW: begin
                csr_wdata = rs1_data;
            end
            // set bits, old value from the read slot
            F3_CSRRS: begin
                csr_wdata = rs1_data | csr_rdata;
            end
            default: begin
                csr_wdata = pc;
            end
        endcase
    end

endmodule

// File: hdl/rv32e_reg_top.sv
// Decode-stage register state of the RV32E core: GPRs plus four machine CSRs.
// All reads are combinational on the current instruction word.
// Write enables are plain levels; no handshake and no back-pressure.
// rd uses instruction bits 10:7 only, as RV32E has sixteen registers.

module rv32e_reg_top (
    input  logic                 clk,
    input  logic                 rst,
    input  rv32e_reg_pkg::inst_t inst,
    input  rv32e_reg_pkg::word_t pc,
    input  logic                 reg_wr,
    input  rv32e_reg_pkg::word_t wb_data,
    input  logic                 csr_wr,
    output rv32e_reg_pkg::word_t rs1_data,
    output rv32e_reg_pkg::word_t rs2_data,
    output rv32e_reg_pkg::word_t csr_rdata
);

    import rv32e_reg_pkg::*;

    gpr_idx_t  rs1;
    gpr_idx_t  rs2;
    gpr_idx_t  rd;
    csr_addr_t csr_addr;
    funct3_t   funct3;
    word_t     csr_wdata;

    // instruction fields
    assign rs1      = inst[18:15];
    assign rs2      = inst[23:20];
    assign rd       = inst[10:7];
    assign csr_addr = inst[31:20];
    assign funct3   = inst[14:12];

    gpr_file gpr0 (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .reg_wr   (reg_wr),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    csr_file csr0 (
        .clk       (clk),
        .rst       (rst),
        .csr_addr  (csr_addr),
        .csr_wr    (csr_wr),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata)
    );

    // write data from the pre-edge reads of both stores
    csr_update upd0 (
        .funct3    (funct3),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .csr_rdata (csr_rdata),
        .csr_wdata (csr_wdata)
    );

endmodule

// File: bench/rv32e_reg_sva.sv
// Assertions bound into gpr_file and csr_file.
// Two watched words must hold their reset values one cycle after any reset cycle.
// With KEEP_FIRST set the first word must also never leave its reset value (x0).

module rv32e_reg_sva #(
    parameter rv32e_reg_pkg::word_t FIRST_RST  = '0,
    parameter rv32e_reg_pkg::word_t SECOND_RST = '0,
    parameter bit                   KEEP_FIRST = 1'b0
) (
    input logic                 clk,
    input logic                 rst,
    input rv32e_reg_pkg::word_t first,
    input rv32e_reg_pkg::word_t second
);

    timeunit 1ns;
    timeprecision 1ps;

    int   fails;
    int   reset_fails = 0;
    int   keep_fails = 0;
    logic rst_seen = 1'b0;

    assign fails = reset_fails + keep_fails;

    always @(posedge clk) begin
        if (rst) begin
            rst_seen <= 1'b1;
        end
    end

    reset_values: assert property (
        @(posedge clk) rst |=> (first == FIRST_RST && second == SECOND_RST)
    ) else begin
        reset_fails++;
        $error("reset value lost: first %08h, second %08h", first, second);
    end

    if (KEEP_FIRST) begin : g_keep
        first_stays: assert property (
            @(posedge clk) disable iff (rst) rst_seen |-> first == FIRST_RST
        ) else begin
            keep_fails++;
            $error("constant register changed to %08h", first);
        end
    end

endmodule

// x0 must stay zero; x15 only checked at reset
bind gpr_file rv32e_reg_sva #(
    .FIRST_RST  ('0),
    .SECOND_RST ('0),
    .KEEP_FIRST (1'b1)
) chk0 (
    .clk    (clk),
    .rst    (rst),
    .first  (regs[0]),
    .second (regs[15])
);

bind csr_file rv32e_reg_sva #(
    .FIRST_RST  (rv32e_reg_pkg::MSTATUS_RST),
    .SECOND_RST (rv32e_reg_pkg::MCAUSE_RST),
    .KEEP_FIRST (1'b0)
) chk0 (
    .clk    (clk),
    .rst    (rst),
    .first  (csr_q[rv32e_reg_pkg::CSR_MSTATUS]),
    .second (csr_q[rv32e_reg_pkg::CSR_MCAUSE])
);

// File: bench/rv32e_reg_tb.sv
// Testbench for rv32e_reg_top, driven by bench/rv32e_reg_tests.txt.
// One test line is one clock cycle. Inputs change on the rising edge and the
// combinational reads are checked on the falling edge, before that line's writes land.
// Lines whose name starts with lcg take wb_data from an LCG and their expected
// GPR reads from a model array; their CSR read is still taken from the file.

module rv32e_reg_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rv32e_reg_pkg::*;

    localparam string TEST_FILE = "bench/rv32e_reg_tests.txt";

    logic  clk = 1'b0;
    logic  rst;
    inst_t inst;
    word_t pc;
    logic  reg_wr;
    word_t wb_data;
    logic  csr_wr;
    word_t rs1_data;
    word_t rs2_data;
    word_t csr_rdata;

    // test table, one entry per line of the file
    string t_name [$];
    logic  t_reg_wr [$];
    logic  t_csr_wr [$];
    inst_t t_inst [$];
    word_t t_pc [$];
    word_t t_wb [$];
    word_t t_exp_rs1 [$];
    word_t t_exp_rs2 [$];
    word_t t_exp_csr [$];

    int    n_tests = 0;
    logic  loaded = 1'b0;
    int    gpr_errors = 0;
    int    csr_errors = 0;
    int    format_errors = 0;

    word_t model [GPR_NUM];
    word_t cur_wb;
    word_t lcg_state = 32'd11528;

    rv32e_reg_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .inst      (inst),
        .pc        (pc),
        .reg_wr    (reg_wr),
        .wb_data   (wb_data),
        .csr_wr    (csr_wr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .csr_rdata (csr_rdata)
    );

    always #10 clk = ~clk;

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic bit is_lcg(input string name);
        return name.len() >= 3 && name.substr(0, 2) == "lcg";
    endfunction

    // CSR slot that an address field reads, used to tag error lines
    function automatic csr_idx_e read_slot_of(input csr_addr_t addr);
        case (addr)
            ADDR_MSTATUS: return CSR_MSTATUS;
            ADDR_MCAUSE:  return CSR_MCAUSE;
            ADDR_MEPC:    return CSR_MEPC;
            ADDR_MRET:    return CSR_MEPC;
            default:      return CSR_MTVEC;
        endcase
    endfunction

    task automatic check_word(input string name, input string port,
                              input word_t exp, input word_t act);
        if (act !== exp) begin
            gpr_errors++;
            $display("[ERROR] %s %s: expected %08h, actual %08h", name, port, exp, act);
        end
    endtask

    task automatic check_csr(input string name, input csr_idx_e slot,
                             input word_t exp, input word_t act);
        if (act !== exp) begin
            csr_errors++;
            $display("[ERROR] %s csr %s: expected %08h, actual %08h",
                     name, slot.name(), exp, act);
        end
    endtask

    task automatic load_tests();
        int    fd;
        string line;
        string name;
        word_t col [8];
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("could not open the test file %s", TEST_FILE);
            format_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // blank lines and comments
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                if ($sscanf(line, "%s %h %h %h %h %h %h %h %h", name, col[0], col[1],
                            col[2], col[3], col[4], col[5], col[6], col[7]) != 9) begin
                    $display("malformed test line skipped: %s", line);
                    format_errors++;
                    continue;
                end
                t_name.push_back(name);
                t_reg_wr.push_back(col[0][0]);
                t_csr_wr.push_back(col[1][0]);
                t_inst.push_back(col[2]);
                t_pc.push_back(col[3]);
                t_wb.push_back(col[4]);
                t_exp_rs1.push_back(col[5]);
                t_exp_rs2.push_back(col[6]);
                t_exp_csr.push_back(col[7]);
            end
            $fclose(fd);
            n_tests = t_name.size();
            if (n_tests == 0) begin
                $display("the test file holds no tests");
                format_errors++;
            end
        end
    endtask

    task automatic drive_test(input int i);
        word_t data;
        if (is_lcg(t_name[i])) begin
            data = lcg_next();
        end else begin
            data = t_wb[i];
        end
        cur_wb = data;
        inst    <= t_inst[i];
        pc      <= t_pc[i];
        reg_wr  <= t_reg_wr[i];
        wb_data <= data;
        csr_wr  <= t_csr_wr[i];
    endtask

    task automatic check_test(input int i);
        gpr_idx_t a1;
        gpr_idx_t a2;
        gpr_idx_t ad;
        word_t    exp_rs1;
        word_t    exp_rs2;
        a1 = t_inst[i][18:15];
        a2 = t_inst[i][23:20];
        ad = t_inst[i][10:7];
        if (is_lcg(t_name[i])) begin
            exp_rs1 = model[a1];
            exp_rs2 = model[a2];
        end else begin
            exp_rs1 = t_exp_rs1[i];
            exp_rs2 = t_exp_rs2[i];
        end
        check_word(t_name[i], "rs1", exp_rs1, rs1_data);
        check_word(t_name[i], "rs2", exp_rs2, rs2_data);
        check_csr(t_name[i], read_slot_of(t_inst[i][31:20]), t_exp_csr[i], csr_rdata);
        // the write lands on the next edge, x0 ignores it
        if (t_reg_wr[i] && ad != '0) begin
            model[ad] = cur_wb;
        end
    endtask

    task automatic report_results();
        int sva_fails;
        int total;
        sva_fails = dut0.gpr0.chk0.fails + dut0.csr0.chk0.fails;
        total = gpr_errors + csr_errors + format_errors + sva_fails;
        $display("tests %0d, gpr errors %0d, csr errors %0d, format errors %0d, sva %0d",
                 n_tests, gpr_errors, csr_errors, format_errors, sva_fails);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
    endtask

    // watchdog, sized from the number of tests
    initial begin
        wait (loaded);
        repeat (n_tests + 40) #20;
        $display("watchdog: run did not finish within %0d cycles", n_tests + 40);
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst     = 1'b1;
        inst    = '0;
        pc      = '0;
        reg_wr  = 1'b0;
        wb_data = '0;
        csr_wr  = 1'b0;
        for (int r = 0; r < GPR_NUM; r++) begin
            model[r] = '0;
        end
        load_tests();
        if (format_errors == 0) begin
            loaded = 1'b1;
            repeat (16) @(posedge clk);
            rst <= 1'b0;
            for (int i = 0; i < n_tests; i++) begin
                @(posedge clk);
                drive_test(i);
                @(negedge clk);
                check_test(i);
            end
        end
        report_results();
        $finish;
    end

endmodule

// File: bench/rv32e_reg_tests.txt
# columns name reg_wr csr_wr inst pc wb_data exp_rs1 exp_rs2 exp_csr (numbers in hex)
# lcg lines get wb_data and the expected rs1 and rs2 reads from the bench LCG and model
rst_rd0       0 0 00800033 00000000 00000000 00000000 00000000 00000000
rst_rd1       0 0 00908033 00000000 00000000 00000000 00000000 00000000
rst_rd2       0 0 00A10033 00000000 00000000 00000000 00000000 00000000
rst_rd3       0 0 00B18033 00000000 00000000 00000000 00000000 00000000
rst_rd4       0 0 00C20033 00000000 00000000 00000000 00000000 00000000
rst_rd5       0 0 00D28033 00000000 00000000 00000000 00000000 00000000
rst_rd6       0 0 00E30033 00000000 00000000 00000000 00000000 00000000
rst_rd7       0 0 00F38033 00000000 00000000 00000000 00000000 00000000
rst_mstatus   0 0 30001073 00000000 00000000 00000000 00000000 00001800
rst_mtvec     0 0 30501073 00000000 00000000 00000000 00000000 00000000
rst_mepc      0 0 34101073 00000000 00000000 00000000 00000000 00000000
rst_mcause    0 0 34201073 00000000 00000000 00000000 00000000 0000000b
w_x1          1 0 002080B3 00000000 12345678 00000000 00000000 00000000
rd_x1         0 0 00108033 00000000 00000000 12345678 12345678 00000000
w_x2          1 0 00110133 00000000 deadbeef 00000000 12345678 00000000
rd_x2         0 0 00110033 00000000 00000000 deadbeef 12345678 00000000
w_x0          1 0 00000033 00000000 ffffffff 00000000 00000000 00000000
rd_x0         0 0 00200033 00000000 00000000 00000000 deadbeef 00000000
w_x15         1 0 00F787B3 00000000 0f0f0f0f 00000000 00000000 00000000
rd_x15        0 0 00078033 00000000 00000000 0f0f0f0f 00000000 00000000
ow_x1         1 0 002080B3 00000000 a5a5a5a5 12345678 deadbeef 00000000
rd_ow_x1      0 0 00F08033 00000000 00000000 a5a5a5a5 0f0f0f0f 00000000
w_x3          1 0 000001B3 00000000 00000080 00000000 00000000 00000000
w_x4          1 0 00000233 00000000 00000008 00000000 00000000 00000000
csrrw_mtvec   0 1 30519073 00000000 00000000 00000080 00000000 00000000
rd_mtvec      0 0 30519073 00000000 00000000 00000080 00000000 00000080
csrrw_mstatus 0 1 30011073 00000000 00000000 deadbeef 00000000 00001800
rd_mstatus    0 0 30011073 00000000 00000000 deadbeef 00000000 deadbeef
csrrw_mepc    0 1 34179073 00000000 00000000 0f0f0f0f a5a5a5a5 00000000
rd_mepc       0 0 34179073 00000000 00000000 0f0f0f0f a5a5a5a5 0f0f0f0f
csrrw_mcause  0 1 34209073 00000000 00000000 a5a5a5a5 deadbeef 0000000b
rd_mcause     0 0 34209073 00000000 00000000 a5a5a5a5 deadbeef a5a5a5a5
csrrs_mtvec   0 1 30522073 00000000 00000000 00000008 00000000 00000080
rd_mtvec2     0 0 30522073 00000000 00000000 00000008 00000000 00000088
csrrs_mcause  0 1 3427A073 00000000 00000000 0f0f0f0f deadbeef a5a5a5a5
rd_mcause2    0 0 3427A073 00000000 00000000 0f0f0f0f deadbeef afafafaf
csrrs_zero    0 1 30002073 00000000 00000000 00000000 00000000 deadbeef
rd_mstatus2   0 0 30002073 00000000 00000000 00000000 00000000 deadbeef
ecall         0 1 00000073 00000400 00000000 00000000 00000000 00000088
mret          0 0 30200073 00000088 00000000 00000000 deadbeef 00000400
bad_addr      0 1 7C000073 00000500 00000000 00000000 00000000 00000088
rd_mepc2      0 0 34101073 00000000 00000000 00000000 a5a5a5a5 00000500
lcg_01        1 0 006282B3 00000000 00000000 00000000 00000000 00000088
lcg_02        1 0 00628333 00000000 00000000 00000000 00000000 00000088
lcg_03        1 0 005303B3 00000000 00000000 00000000 00000000 00000088
lcg_04        0 0 00538033 00000000 00000000 00000000 00000000 00000088
lcg_05        1 0 00838433 00000000 00000000 00000000 00000000 00000088
lcg_06        1 0 005402B3 00000000 00000000 00000000 00000000 00000088
lcg_07        1 0 009284B3 00000000 00000000 00000000 00000000 00000088
lcg_08        1 0 00A48533 00000000 00000000 00000000 00000000 00000088
lcg_09        0 0 00650033 00000000 00000000 00000000 00000000 00000088
lcg_10        1 0 00A00033 00000000 00000000 00000000 00000000 00000088
lcg_11        1 0 008005B3 00000000 00000000 00000000 00000000 00000088
lcg_12        0 0 00758033 00000000 00000000 00000000 00000000 00000088
lcg_13        1 0 00C58633 00000000 00000000 00000000 00000000 00000088
lcg_14        0 0 00960033 00000000 00000000 00000000 00000000 00000088

// File: filelist.f
hdl/rv32e_reg_pkg.sv
hdl/gpr_file.sv
hdl/csr_file.sv
hdl/csr_update.sv
hdl/rv32e_reg_top.sv
bench/rv32e_reg_sva.sv
bench/rv32e_reg_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the RV32E register state testbench with Verilator and runs it.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module rv32e_reg_tb \
    -o rv32e_reg_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/rv32e_reg_sim +verilator+error+limit+100)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "All checks passed" <<< "$sim_out"; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi
